//--- common/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    // zero, carry, negative, overflow from msb down
    typedef logic [3:0]  flags_t;

    typedef enum logic [3:0] {
        PASS = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        AND  = 4'h3,
        OR   = 4'h4,
        XOR  = 4'h5,
        SHL  = 4'h6,
        SHR  = 4'h7
    } alu_op_e;

    typedef enum logic [3:0] {
        NONE, EQ, NE, LTU, GTU, LEU, GEU, LTS, GTS, LES, GES
    } cond_e;

    // alu instructions use 8'hF? with the alu op in the low nibble
    typedef enum logic [7:0] {
        NOP  = 8'h00,
        LD   = 8'h01,
        LDR  = 8'h02,
        LDI  = 8'h03,
        ST   = 8'h04,
        STR  = 8'h05,
        PUSH = 8'h06,
        POP  = 8'h07,
        INT  = 8'h08
    } opcode_e;

    typedef enum logic {
        USER       = 1'b0,
        SUPERVISOR = 1'b1
    } mode_e;

    localparam reg_idx_t REG_SP     = 4'd13;
    localparam reg_idx_t REG_STATUS = 4'd14;
    localparam reg_idx_t REG_PC     = 4'd15;

    // vector slots, scaled to word addresses on the B bus
    localparam reg_idx_t HWINT_VEC  = 4'd1;
    localparam reg_idx_t SWINT_VEC  = 4'd2;
    localparam reg_idx_t EXCEPT_VEC = 4'd3;

    localparam word_t RESET_SP   = 32'h0000_1000;
    localparam word_t WORD_BYTES = 32'd4;

    localparam int F_Z = 3;
    localparam int F_C = 2;
    localparam int F_N = 1;
    localparam int F_V = 0;

    // instruction fields
    localparam int COND_HI   = 31;
    localparam int COND_LO   = 28;
    localparam int OPC_HI    = 27;
    localparam int OPC_LO    = 20;
    localparam int RA_HI     = 19;
    localparam int RA_LO     = 16;
    localparam int RB_HI     = 15;
    localparam int RB_LO     = 12;
    localparam int RC_HI     = 11;
    localparam int RC_LO     = 8;
    localparam int IMM_BIT   = 7;
    localparam int REV_BIT   = 6;
    localparam int LOADN_BIT = 5;
    localparam int SETST_BIT = 4;

    // LDI into the status register
    localparam int ST_MODE_BIT  = 0;
    localparam int ST_IMASK_BIT = 1;

endpackage

//--- logic/alu.sv
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flags_t  flags_out
);
    import cpu_pkg::*;

    logic [32:0] wide;
    logic        carry;
    logic        ovf;

    always_comb begin
        wide  = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            PASS: wide[31:0] = b;
            ADD: begin
                wide  = {1'b0, a} + {1'b0, b};
                carry = wide[32];
                ovf   = (a[31] == b[31]) && (wide[31] != a[31]);
            end
            SUB: begin
                wide  = {1'b0, a} - {1'b0, b};
                // carry set means no borrow
                carry = !wide[32];
                ovf   = (a[31] != b[31]) && (wide[31] != a[31]);
            end
            AND: wide[31:0] = a & b;
            OR:  wide[31:0] = a | b;
            XOR: wide[31:0] = a ^ b;
            SHL: begin
                wide  = {1'b0, a} << b[4:0];
                carry = wide[32];
            end
            SHR: begin
                wide[31:0] = a >> b[4:0];
                // last bit shifted out
                carry      = (b[4:0] != 5'd0) ? a[b[4:0] - 5'd1] : 1'b0;
            end
            default: wide[31:0] = b;
        endcase
        result         = wide[31:0];
        flags_out[F_Z] = (result == '0);
        flags_out[F_C] = carry;
        flags_out[F_N] = result[31];
        flags_out[F_V] = ovf;
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic              rst,
    input  logic              arst_n,
    input  cpu_pkg::reg_idx_t sel_a,
    input  cpu_pkg::reg_idx_t sel_b,
    input  cpu_pkg::reg_idx_t sel_in,
    input  cpu_pkg::word_t    wr_data,
    input  logic              ld,
    input  logic              post_inc_pc,
    input  logic              post_inc_sp,
    input  logic              pre_dec_sp,
    output cpu_pkg::word_t    rd_a,
    output cpu_pkg::word_t    rd_b
);
    import cpu_pkg::*;

    word_t gpr [16];
    word_t pc_q;
    word_t sp_q;

    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == REG_PC) begin
            return pc_q;
        end else if (idx == REG_SP) begin
            return sp_q;
        end
        return gpr[idx];
    endfunction

    // a load wins over the increments
    always_ff @(posedge rst or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= '0;
            sp_q <= RESET_SP;
        end else begin
            if (ld && sel_in == REG_PC) begin
                pc_q <= wr_data;
            end else if (post_inc_pc) begin
                pc_q <= pc_q + WORD_BYTES;
            end
            if (ld && sel_in == REG_SP) begin
                sp_q <= wr_data;
            end else if (post_inc_sp) begin
                sp_q <= sp_q + WORD_BYTES;
            end
        end
    end

    always_ff @(posedge rst) begin
        if (ld && sel_in != REG_PC && sel_in != REG_SP) begin
            gpr[sel_in] <= wr_data;
        end
    end

    assign rd_a = read_reg(sel_a);
    // push address
    assign rd_b = (pre_dec_sp && sel_b == REG_SP) ? sp_q - WORD_BYTES : read_reg(sel_b);

endmodule

//--- logic/status_reg.sv
`timescale 1ns/100ps

module status_reg (
    input  logic            rst,
    input  logic            arst_n,
    input  logic            ld_flags,
    input  cpu_pkg::flags_t flags_in,
    input  logic            ld_imask,
    input  logic            imask_in,
    input  logic            ld_mode,
    input  cpu_pkg::mode_e  mode_in,
    output cpu_pkg::flags_t flags,
    output logic            imask,
    output cpu_pkg::mode_e  mode
);
    import cpu_pkg::*;

    // start in supervisor with interrupts enabled
    always_ff @(posedge rst or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
            imask <= 1'b1;
            mode  <= SUPERVISOR;
        end else begin
            if (ld_flags) begin
                flags <= flags_in;
            end
            if (ld_imask) begin
                imask <= imask_in;
            end
            if (ld_mode) begin
                mode <= mode_in;
            end
        end
    end

endmodule

//--- logic/operand_path.sv
`timescale 1ns/100ps

module operand_path (
    input  cpu_pkg::word_t    ir,
    input  cpu_pkg::word_t    rd_a,
    input  cpu_pkg::word_t    rd_b,
    input  cpu_pkg::reg_idx_t sel_b_reg,
    input  logic              oe_a_reg,
    input  logic              oe_a_ir,
    input  logic              oe_a_consts,
    input  logic              oe_b_reg,
    input  logic              oe_b_ir,
    input  logic              oe_b_consts,
    input  logic              a_mask_16,
    input  logic              a_mask_8,
    input  logic              b_mask_16,
    input  logic              b_mask_8,
    output cpu_pkg::word_t    a_bus,
    output cpu_pkg::word_t    b_bus
);
    import cpu_pkg::*;

    word_t const_val;
    word_t a_raw;
    word_t b_raw;

    function automatic word_t apply_mask(input word_t v, input logic m16, input logic m8);
        if (m8) begin
            return {24'b0, v[7:0]};
        end else if (m16) begin
            return {16'b0, v[15:0]};
        end
        return v;
    endfunction

    // vector slots are one word apart
    assign const_val = {26'b0, sel_b_reg, 2'b00};

    assign a_raw = oe_a_reg ? rd_a : oe_a_ir ? ir : oe_a_consts ? const_val : '0;
    assign b_raw = oe_b_reg ? rd_b : oe_b_ir ? ir : oe_b_consts ? const_val : '0;

    assign a_bus = apply_mask(a_raw, a_mask_16, a_mask_8);
    assign b_bus = apply_mask(b_raw, b_mask_16, b_mask_8);

endmodule

//--- logic/bus_master.sv
`timescale 1ns/100ps

module bus_master (
    input  logic           rst,
    input  logic           arst_n,
    input  logic           mem_rd,
    input  logic           mem_wr,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    input  logic           wb_ack,
    input  cpu_pkg::word_t wb_dat_r,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_dat_w,
    output cpu_pkg::word_t rdata,
    output logic           done
);
    import cpu_pkg::*;

    typedef enum logic {
        BM_IDLE,
        BM_ACTIVE
    } bm_state_e;

    bm_state_e state_q;

    // one idle cycle after ack lets the cu leave its state
    always_ff @(posedge rst or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= BM_IDLE;
        end else if (state_q == BM_IDLE) begin
            if (mem_rd || mem_wr) begin
                state_q <= BM_ACTIVE;
            end
        end else if (wb_ack) begin
            state_q <= BM_IDLE;
        end
    end

    always_ff @(posedge rst) begin
        if (state_q == BM_IDLE) begin
            wb_adr   <= addr;
            wb_dat_w <= wdata;
            wb_we    <= mem_wr;
        end
    end

    assign wb_cyc = (state_q == BM_ACTIVE);
    assign wb_stb = (state_q == BM_ACTIVE);
    assign done   = (state_q == BM_ACTIVE) && wb_ack;
    assign rdata  = wb_dat_r;

endmodule

//--- control/cu.sv
`timescale 1ns/100ps

module cu (
    input  logic              rst,
    input  logic              arst_n,
    input  logic              start,
    input  logic              hwint,
    input  cpu_pkg::word_t    ir,
    input  cpu_pkg::flags_t   flags,
    input  logic              imask,
    input  cpu_pkg::mode_e    mode,
    input  logic              done,
    output cpu_pkg::word_t    ir_q,
    output logic              mem_rd,
    output logic              mem_wr,
    output cpu_pkg::alu_op_e  alu_op,
    output logic              oe_alu,
    output cpu_pkg::reg_idx_t sel_a_reg,
    output cpu_pkg::reg_idx_t sel_b_reg,
    output cpu_pkg::reg_idx_t sel_in_reg,
    output logic              oe_a_reg,
    output logic              oe_b_reg,
    output logic              oe_a_ir,
    output logic              oe_b_ir,
    output logic              oe_a_consts,
    output logic              oe_b_consts,
    output logic              a_mask_16,
    output logic              a_mask_8,
    output logic              b_mask_16,
    output logic              b_mask_8,
    output logic              ld_reg,
    output logic              ld_ir,
    output logic              post_inc_pc,
    output logic              post_inc_sp,
    output logic              pre_dec_sp,
    output logic              ld_alu_status,
    output logic              ld_imask,
    output logic              imask_in,
    output logic              ld_mode,
    output cpu_pkg::mode_e    mode_in
);
    import cpu_pkg::*;

    typedef enum logic [4:0] {
        S_STOP, S_FETCH, S_DECODE,
        S_LD, S_LDR, S_LDI, S_ST, S_STR, S_PUSH, S_POP, S_ALU,
        S_HWINT1, S_HWINT2, S_SWINT1, S_SWINT2, S_EXCEPT1, S_EXCEPT2
    } state_e;

    state_e   state_q;
    state_e   state_d;
    reg_idx_t ra;
    reg_idx_t rb;
    reg_idx_t rc;
    logic     irq;
    logic     locked;
    logic     loadn;
    logic     alu_bad;

    assign ra      = ir_q[RA_HI:RA_LO];
    assign rb      = ir_q[RB_HI:RB_LO];
    assign rc      = ir_q[RC_HI:RC_LO];
    assign loadn   = ir_q[LOADN_BIT];
    assign irq     = hwint & imask;
    // status writes need supervisor mode
    assign locked  = (ra == REG_STATUS) && (mode != SUPERVISOR);
    assign alu_bad = ir_q[OPC_LO +: 4] > SHR;

    function automatic logic cond_ok(input cond_e c, input flags_t f);
        logic z;
        logic cy;
        logic sv;
        z  = f[F_Z];
        cy = f[F_C];
        sv = f[F_N] ^ f[F_V];
        case (c)
            EQ:      return z;
            NE:      return !z;
            LTU:     return !cy;
            GTU:     return cy && !z;
            LEU:     return !cy || z;
            GEU:     return cy;
            LTS:     return sv;
            GTS:     return !z && !sv;
            LES:     return z || sv;
            GES:     return !sv;
            default: return 1'b1;
        endcase
    endfunction

    always_ff @(posedge rst or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_STOP;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge rst) begin
        if (ld_ir) begin
            ir_q <= ir;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_STOP:    if (start) state_d = S_FETCH;
            S_FETCH:   if (done) state_d = irq ? S_HWINT1 : S_DECODE;
            S_DECODE: begin
                if (!cond_ok(cond_e'(ir_q[COND_HI:COND_LO]), flags)) begin
                    state_d = S_FETCH;
                end else begin
                    casez (opcode_e'(ir_q[OPC_HI:OPC_LO]))
                        NOP:  state_d = S_FETCH;
                        LD:   state_d = locked ? S_EXCEPT1 : S_LD;
                        LDR:  state_d = locked ? S_EXCEPT1 : S_LDR;
                        LDI:  state_d = locked ? S_EXCEPT1 : S_LDI;
                        ST:   state_d = S_ST;
                        STR:  state_d = S_STR;
                        PUSH: state_d = S_PUSH;
                        POP:  state_d = locked ? S_EXCEPT1 : S_POP;
                        INT:  state_d = S_SWINT1;
                        8'b1111_????: begin
                            if (alu_bad || (locked && !loadn)) begin
                                state_d = S_EXCEPT1;
                            end else begin
                                state_d = S_ALU;
                            end
                        end
                        default: state_d = S_EXCEPT1;
                    endcase
                end
            end
            S_LD, S_LDR, S_ST, S_STR, S_PUSH, S_POP: if (done) state_d = S_FETCH;
            S_HWINT1:  if (done) state_d = S_HWINT2;
            S_SWINT1:  if (done) state_d = S_SWINT2;
            S_EXCEPT1: if (done) state_d = S_EXCEPT2;
            default:   state_d = S_FETCH;
        endcase
    end

    always_comb begin
        mem_rd        = 1'b0;
        mem_wr        = 1'b0;
        alu_op        = PASS;
        oe_alu        = 1'b0;
        sel_a_reg     = '0;
        sel_b_reg     = '0;
        sel_in_reg    = '0;
        oe_a_reg      = 1'b0;
        oe_b_reg      = 1'b0;
        oe_a_ir       = 1'b0;
        oe_b_ir       = 1'b0;
        oe_a_consts   = 1'b0;
        oe_b_consts   = 1'b0;
        a_mask_16     = 1'b0;
        a_mask_8      = 1'b0;
        b_mask_16     = 1'b0;
        b_mask_8      = 1'b0;
        ld_reg        = 1'b0;
        ld_ir         = 1'b0;
        post_inc_pc   = 1'b0;
        post_inc_sp   = 1'b0;
        pre_dec_sp    = 1'b0;
        ld_alu_status = 1'b0;
        ld_imask      = 1'b0;
        imask_in      = 1'b0;
        ld_mode       = 1'b0;
        mode_in       = USER;

        case (state_q)
            // ir <- *(pc++), dropped when an interrupt is taken
            S_FETCH: begin
                sel_b_reg   = REG_PC;
                oe_b_reg    = 1'b1;
                mem_rd      = 1'b1;
                ld_ir       = !irq;
                post_inc_pc = !irq;
            end
            S_LD: begin
                oe_b_ir    = 1'b1;
                b_mask_16  = 1'b1;
                mem_rd     = 1'b1;
                sel_in_reg = ra;
                ld_reg     = 1'b1;
            end
            S_LDR: begin
                sel_b_reg  = rb;
                oe_b_reg   = 1'b1;
                mem_rd     = 1'b1;
                sel_in_reg = ra;
                ld_reg     = 1'b1;
            end
            S_LDI: begin
                oe_b_ir    = 1'b1;
                b_mask_16  = 1'b1;
                oe_alu     = 1'b1;
                sel_in_reg = ra;
                ld_reg     = 1'b1;
                // supervisor can set mode and imask this way
                if (ra == REG_STATUS) begin
                    ld_mode  = 1'b1;
                    mode_in  = mode_e'(ir_q[ST_MODE_BIT]);
                    ld_imask = 1'b1;
                    imask_in = ir_q[ST_IMASK_BIT];
                end
            end
            S_ST, S_STR: begin
                sel_a_reg = ra;
                oe_a_reg  = 1'b1;
                sel_b_reg = rb;
                oe_b_reg  = (state_q == S_STR);
                oe_b_ir   = (state_q == S_ST);
                b_mask_16 = (state_q == S_ST);
                mem_wr    = 1'b1;
            end
            // *(--sp) <- reg, new sp written back through the alu
            S_PUSH, S_HWINT1, S_SWINT1, S_EXCEPT1: begin
                sel_a_reg  = (state_q == S_PUSH) ? ra : REG_PC;
                oe_a_reg   = 1'b1;
                sel_b_reg  = REG_SP;
                oe_b_reg   = 1'b1;
                pre_dec_sp = 1'b1;
                mem_wr     = 1'b1;
                oe_alu     = 1'b1;
                sel_in_reg = REG_SP;
                ld_reg     = 1'b1;
            end
            S_POP: begin
                sel_b_reg   = REG_SP;
                oe_b_reg    = 1'b1;
                mem_rd      = 1'b1;
                sel_in_reg  = ra;
                ld_reg      = 1'b1;
                post_inc_sp = 1'b1;
            end
            S_ALU: begin
                if (ir_q[IMM_BIT]) begin
                    if (ir_q[REV_BIT]) begin
                        oe_a_ir   = 1'b1;
                        a_mask_8  = 1'b1;
                        sel_b_reg = rb;
                        oe_b_reg  = 1'b1;
                    end else begin
                        sel_a_reg = rb;
                        oe_a_reg  = 1'b1;
                        oe_b_ir   = 1'b1;
                        b_mask_8  = 1'b1;
                    end
                end else begin
                    sel_a_reg = ir_q[REV_BIT] ? rc : rb;
                    sel_b_reg = ir_q[REV_BIT] ? rb : rc;
                    oe_a_reg  = 1'b1;
                    oe_b_reg  = 1'b1;
                end
                alu_op        = alu_op_e'(ir_q[OPC_LO +: 4]);
                oe_alu        = !loadn;
                sel_in_reg    = ra;
                ld_reg        = !loadn;
                ld_alu_status = ir_q[SETST_BIT];
            end
            // pc <- vector, always entered in supervisor mode
            S_HWINT2, S_SWINT2, S_EXCEPT2: begin
                if (state_q == S_HWINT2) begin
                    sel_b_reg = HWINT_VEC;
                end else if (state_q == S_SWINT2) begin
                    sel_b_reg = SWINT_VEC;
                end else begin
                    sel_b_reg = EXCEPT_VEC;
                end
                oe_b_consts = 1'b1;
                oe_alu      = 1'b1;
                sel_in_reg  = REG_PC;
                ld_reg      = 1'b1;
                ld_imask    = (state_q != S_EXCEPT2);
                ld_mode     = 1'b1;
                mode_in     = SUPERVISOR;
            end
            default: ;
        endcase

        // hold all updates while the bus cycle is pending
        if (mem_rd || mem_wr) begin
            ld_reg        = ld_reg & done;
            ld_ir         = ld_ir & done;
            post_inc_pc   = post_inc_pc & done;
            post_inc_sp   = post_inc_sp & done;
            ld_alu_status = ld_alu_status & done;
            ld_imask      = ld_imask & done;
            ld_mode       = ld_mode & done;
        end
    end

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic           rst,
    input  logic           arst_n,
    input  logic           start,
    input  logic           hwint,
    input  logic           wb_ack,
    input  cpu_pkg::word_t wb_dat_r,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_dat_w
);
    import cpu_pkg::*;

    word_t    ir_q;
    word_t    rd_a;
    word_t    rd_b;
    word_t    a_bus;
    word_t    b_bus;
    word_t    alu_result;
    word_t    mem_data;
    word_t    wr_data;
    flags_t   flags;
    flags_t   alu_flags;
    mode_e    mode;
    mode_e    mode_in;
    alu_op_e  alu_op;
    reg_idx_t sel_a_reg;
    reg_idx_t sel_b_reg;
    reg_idx_t sel_in_reg;
    logic     imask;
    logic     imask_in;
    logic     done;
    logic     mem_rd;
    logic     mem_wr;
    logic     oe_alu;
    logic     oe_a_reg;
    logic     oe_b_reg;
    logic     oe_a_ir;
    logic     oe_b_ir;
    logic     oe_a_consts;
    logic     oe_b_consts;
    logic     a_mask_16;
    logic     a_mask_8;
    logic     b_mask_16;
    logic     b_mask_8;
    logic     ld_reg;
    logic     post_inc_pc;
    logic     post_inc_sp;
    logic     pre_dec_sp;
    logic     ld_alu_status;
    logic     ld_imask;
    logic     ld_mode;

    // write-back source
    assign wr_data = mem_rd ? mem_data : (oe_alu ? alu_result : '0);

    cu u_cu (
        .rst(rst), .arst_n(arst_n), .start(start), .hwint(hwint),
        .ir(mem_data), .flags(flags), .imask(imask), .mode(mode), .done(done),
        .ir_q(ir_q), .mem_rd(mem_rd), .mem_wr(mem_wr), .alu_op(alu_op), .oe_alu(oe_alu),
        .sel_a_reg(sel_a_reg), .sel_b_reg(sel_b_reg), .sel_in_reg(sel_in_reg),
        .oe_a_reg(oe_a_reg), .oe_b_reg(oe_b_reg), .oe_a_ir(oe_a_ir), .oe_b_ir(oe_b_ir),
        .oe_a_consts(oe_a_consts), .oe_b_consts(oe_b_consts),
        .a_mask_16(a_mask_16), .a_mask_8(a_mask_8),
        .b_mask_16(b_mask_16), .b_mask_8(b_mask_8),
        .ld_reg(ld_reg), .ld_ir(),
        .post_inc_pc(post_inc_pc), .post_inc_sp(post_inc_sp), .pre_dec_sp(pre_dec_sp),
        .ld_alu_status(ld_alu_status), .ld_imask(ld_imask), .imask_in(imask_in),
        .ld_mode(ld_mode), .mode_in(mode_in)
    );

    reg_file u_reg_file (
        .rst(rst), .arst_n(arst_n),
        .sel_a(sel_a_reg), .sel_b(sel_b_reg), .sel_in(sel_in_reg),
        .wr_data(wr_data), .ld(ld_reg),
        .post_inc_pc(post_inc_pc), .post_inc_sp(post_inc_sp), .pre_dec_sp(pre_dec_sp),
        .rd_a(rd_a), .rd_b(rd_b)
    );

    status_reg u_status_reg (
        .rst(rst), .arst_n(arst_n),
        .ld_flags(ld_alu_status), .flags_in(alu_flags),
        .ld_imask(ld_imask), .imask_in(imask_in),
        .ld_mode(ld_mode), .mode_in(mode_in),
        .flags(flags), .imask(imask), .mode(mode)
    );

    alu u_alu (
        .op(alu_op), .a(a_bus), .b(b_bus),
        .result(alu_result), .flags_out(alu_flags)
    );

    operand_path u_operand_path (
        .ir(ir_q), .rd_a(rd_a), .rd_b(rd_b), .sel_b_reg(sel_b_reg),
        .oe_a_reg(oe_a_reg), .oe_a_ir(oe_a_ir), .oe_a_consts(oe_a_consts),
        .oe_b_reg(oe_b_reg), .oe_b_ir(oe_b_ir), .oe_b_consts(oe_b_consts),
        .a_mask_16(a_mask_16), .a_mask_8(a_mask_8),
        .b_mask_16(b_mask_16), .b_mask_8(b_mask_8),
        .a_bus(a_bus), .b_bus(b_bus)
    );

    bus_master u_bus_master (
        .rst(rst), .arst_n(arst_n), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .addr(b_bus), .wdata(a_bus), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .rdata(mem_data), .done(done)
    );

endmodule

//--- testbench/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int MEM_WORDS     = 1024;
    localparam int PAT_WORDS     = 2048;
    // expected write section of the pattern image
    localparam int REC_BASE      = 1024;
    localparam int REC_MAX       = 500;
    localparam int SETTLE_CYCLES = 50;

    logic        rst;
    logic        arst_n;
    logic        start;
    logic        hwint;
    logic        wb_ack;
    word_t       wb_dat_r;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    word_t       wb_adr;
    word_t       wb_dat_w;

    word_t       pat [PAT_WORDS];
    word_t       mem [MEM_WORDS];
    logic [31:0] lfsr;
    logic [1:0]  wait_left;
    logic        in_cycle;
    logic        bus_released;
    int          rec_count;
    int          hwint_step;
    int          writes_seen;
    int          errors;

    cpu_top DUT (
        .rst(rst), .arst_n(arst_n), .start(start), .hwint(hwint),
        .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w)
    );

    always #10 rst = ~rst;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h (write %0d)", name, got, exp, writes_seen + 1);
            errors++;
        end
    endtask

    task automatic record_write(input word_t adr, input word_t data);
        if (writes_seen >= rec_count) begin
            $display("unexpected write of %h to address %h after all %0d expected writes",
                     data, adr, rec_count);
            errors++;
        end else begin
            compare_value("wb_adr", adr, pat[REC_BASE + 2 + 2 * writes_seen]);
            compare_value("wb_dat_w", data, pat[REC_BASE + 3 + 2 * writes_seen]);
        end
    endtask

    // wishbone slave with 0 to 3 wait cycles per access
    always @(posedge rst) begin
        if (wb_ack) begin
            wb_ack       <= 1'b0;
            in_cycle     = 1'b0;
            bus_released = 1'b1;
            if (wb_we) begin
                mem[wb_adr[11:2]] = wb_dat_w;
                record_write(wb_adr, wb_dat_w);
                writes_seen++;
                // hwint rises after the marked write and falls with the next one
                if (hwint) begin
                    hwint <= 1'b0;
                end else if (writes_seen == hwint_step) begin
                    hwint <= 1'b1;
                end
            end
        end else if (bus_released) begin
            // master must drop cyc and stb in the cycle after ack
            bus_released = 1'b0;
            compare_value("wb_cyc", wb_cyc, 32'd0);
            compare_value("wb_stb", wb_stb, 32'd0);
        end else if (wb_cyc && wb_stb) begin
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                wait_left = 2'd0;
                repeat (2) begin
                    wait_left = {wait_left[0], lfsr[0]};
                    lfsr      = lfsr_next(lfsr);
                end
            end
            if (wait_left == 2'd0) begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[wb_adr[11:2]];
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    initial begin
        int cycles;
        int cycle_limit;

        rst          = 1'b0;
        arst_n       = 1'b0;
        start        = 1'b0;
        hwint        = 1'b0;
        wb_ack       = 1'b0;
        wb_dat_r     = '0;
        lfsr         = 32'hdb16_117b;
        wait_left    = 2'd0;
        in_cycle     = 1'b0;
        bus_released = 1'b0;
        writes_seen  = 0;
        errors       = 0;
        cycles       = 0;

        for (int i = 0; i < PAT_WORDS; i++) begin
            pat[i] = {~i[15:0], i[15:0]};
        end
        $readmemh("testbench/cpu_patterns.hex", pat);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = pat[i];
        end
        rec_count  = pat[REC_BASE];
        hwint_step = pat[REC_BASE + 1];
        if (rec_count < 1 || rec_count > REC_MAX) begin
            $display("pattern file holds no valid count of expected writes");
            errors++;
            rec_count = 0;
        end
        cycle_limit = 40 * rec_count + 200;

        repeat (10) @(posedge rst);
        arst_n <= 1'b1;
        @(posedge rst);
        start <= 1'b1;
        @(posedge rst);
        start <= 1'b0;

        while (writes_seen < rec_count && cycles < cycle_limit) begin
            @(negedge rst);
            cycles++;
        end
        if (writes_seen < rec_count) begin
            $display("timeout after %0d cycles, %0d of %0d expected writes still missing",
                     cycles, rec_count - writes_seen, rec_count);
            errors++;
        end else begin
            // extra writes after the last record still reach the checker
            repeat (SETTLE_CYCLES) @(negedge rst);
        end

        $display("writes seen %0d, expected %0d, errors %0d", writes_seen, rec_count, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- cpu.f
common/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/status_reg.sv
logic/operand_path.sv
logic/bus_master.sv
control/cu.sv
logic/cpu_top.sv
testbench/tb_cpu.sv

//--- testbench/cpu_patterns.hex
// 32-bit hex words, @ gives the word address; program image from @000
// @400: expected write count, hwint trigger write, then address and data pairs
@000
003F0060 003F0020 003F0030 003F0040
@008
003A0A11 004A02F0 007F0000
@00C
003B0B22 004B02F4 003E0002 007F0000
@010
003C0C33 004C02F8 007F0000
@018
00311234 00410200 00320204 0033BEEF 00532000 00140200
00252000 00440208 0045020C 00160300 00460210 00310005
00320007 0F231210 30430214 60430218 1043021C 70430220
0F141210 80440224 20440228 9044022C 0F251110 10450230
40450234 50450238 2F161200 0046023C 1F161200 00460240
00610000 00620000 00770000 00780000 00470244 00480248
00800000 003E0003 00900000 0041024C 00420250 003F0104
@0C0
CAFEF00D
@400
0000001B 00000018
00000200 00001234 00000204 0000BEEF 00000208 00001234 0000020C 0000BEEF
00000210 CAFEF00D 00000214 FFFFFFFE 00000220 FFFFFFFE 00000224 0000000C
00000228 0000000C 00000230 00000000 00000238 00000000 0000023C CAFEF00D
00000240 0000000C 00000FFC 00000005 00000FF8 00000007 00000244 00000007
00000248 00000005 00000FFC 000000F4 000002F4 00000B22 00000FFC 000000F8
000002F8 00000C33 00000FFC 000000FC 000002F8 00000C33 0000024C 00000005
00000FFC 00000100 000002F0 00000A11 00000250 00000007
